//--- keccak_pkg.sv
// Keccak shared definitions
// Round constants, rho offsets, round index type and control state encoding

package keccak_pkg;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Round index, covers up to 24 rounds
  typedef logic [4:0] round_idx_t;

  // Control state of the round sequencer
  typedef enum logic {
    CtrlIdle = 1'b0,
    CtrlRun  = 1'b1
  } ctrl_state_e;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Widest lane, Keccak-f[1600]
  localparam int MaxLaneW = 64;

  // Iota round constants for 64-bit lanes
  // Narrower lanes take the low W bits of each entry
  localparam logic [MaxLaneW-1:0] RoundConst [24] = '{
    64'h0000_0000_0000_0001,
    64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808A,
    64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808B,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008A,
    64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009,
    64'h0000_0000_8000_000A,
    // Rounds 12 to 23, narrow lanes stop earlier
    64'h0000_0000_8000_808B,
    64'h8000_0000_0000_008B,
    64'h8000_0000_0000_8089,
    64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002,
    64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800A,
    64'h8000_0000_8000_000A,
    64'h8000_0000_8000_8081,
    64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8008
  };

  // Rho rotation per lane, indexed 5x+y
  // Raw triangular numbers, reduced modulo W where used
  localparam int RhoOffset [25] = '{
    // x = 0, y = 0..4
      0,  36,   3, 105, 210,
    // x = 1
      1, 300,  10,  45,  66,
    // x = 2
    190,   6, 171,  15, 253,
    // x = 3
     28,  55, 153,  21, 120,
    // x = 4
     91, 276, 231, 136,  78
  };

endpackage

//--- keccak_round_ctrl.sv
// Keccak round sequencer
// Counts rounds after a start pulse and flags load, advance, busy and done

`timescale 1ns/1ps

module keccak_round_ctrl #(
  parameter int Width = 1600
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   start_i,
  output logic                   load_o,
  output logic                   advance_o,
  output keccak_pkg::round_idx_t rnd_o,
  output logic                   busy_o,
  output logic                   done_o
);

  // Lane width and round count of Keccak-f
  localparam int W        = Width / 25;
  localparam int L        = $clog2(W);
  localparam int MaxRound = 12 + 2 * L;

  // Index of the final round
  localparam keccak_pkg::round_idx_t LastRnd = keccak_pkg::round_idx_t'(MaxRound - 1);

  keccak_pkg::ctrl_state_e state_q;
  keccak_pkg::round_idx_t  rnd_q;
  logic                    done_q;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= keccak_pkg::CtrlIdle;
      rnd_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      // Done is a single cycle pulse
      done_q <= 1'b0;
      unique case (state_q)
        keccak_pkg::CtrlIdle: begin
          if (start_i) begin
            state_q <= keccak_pkg::CtrlRun;
            rnd_q   <= '0;
          end
        end
        keccak_pkg::CtrlRun: begin
          if (rnd_q == LastRnd) begin
            // Last round lands on this edge
            state_q <= keccak_pkg::CtrlIdle;
            rnd_q   <= '0;
            done_q  <= 1'b1;
          end else begin
            rnd_q <= rnd_q + 5'd1;
          end
        end
        default: begin
          state_q <= keccak_pkg::CtrlIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Start only taken while idle, ignored mid-run
  assign load_o = start_i && (state_q == keccak_pkg::CtrlIdle);

  // One round per Run cycle
  assign advance_o = (state_q == keccak_pkg::CtrlRun);
  assign rnd_o     = rnd_q;

  assign busy_o = (state_q == keccak_pkg::CtrlRun);
  assign done_o = done_q;

endmodule

//--- keccak_linear_step.sv
// Keccak linear layer
// Theta column mixing, rho lane rotations and pi lane permutation

`timescale 1ns/1ps

module keccak_linear_step #(
  parameter int Width = 1600
) (
  // Lanes in [x][y][z] order, flattened
  input  logic [Width-1:0] state_i,
  output logic [Width-1:0] state_o
);

  localparam int W = Width / 25;

  // Lane arrays, index [x][y][z]
  logic [4:0][4:0][W-1:0] lanes_in;
  logic [4:0][4:0][W-1:0] theta_data;
  logic [4:0][4:0][W-1:0] rho_data;
  logic [4:0][4:0][W-1:0] pi_data;

  // Column parities and theta effect, index [x][z]
  logic [4:0][W-1:0] col_par;
  logic [4:0][W-1:0] theta_d;

  assign lanes_in = state_i;

  ////////////////////////////////////////
  // Theta
  ////////////////////////////////////////

  for (genvar x = 0; x < 5; x++) begin : g_theta_col
    // Neighbour columns
    localparam int XM1 = (x + 4) % 5;
    localparam int XP1 = (x + 1) % 5;

    // Parity over the five lanes of column x
    assign col_par[x] = lanes_in[x][0] ^ lanes_in[x][1] ^ lanes_in[x][2] ^
                        lanes_in[x][3] ^ lanes_in[x][4];

    // C[x-1] xor C[x+1] rotated left by one
    assign theta_d[x] = col_par[XM1] ^ {col_par[XP1][W-2:0], col_par[XP1][W-1]};

    for (genvar y = 0; y < 5; y++) begin : g_theta_row
      assign theta_data[x][y] = lanes_in[x][y] ^ theta_d[x];
    end
  end

  ////////////////////////////////////////
  // Rho
  ////////////////////////////////////////

  // Fixed rotations, resolved at elaboration
  for (genvar x = 0; x < 5; x++) begin : g_rho_x
    for (genvar y = 0; y < 5; y++) begin : g_rho_y
      localparam int Offset = keccak_pkg::RhoOffset[5 * x + y] % W;

      if (Offset == 0) begin : g_pass
        // Lane (0,0) and any offset that wraps to zero
        assign rho_data[x][y] = theta_data[x][y];
      end else begin : g_rot
        // Rotate left, bit z takes bit z-Offset
        assign rho_data[x][y] = {theta_data[x][y][W-1-Offset:0],
                                 theta_data[x][y][W-1:W-Offset]};
      end
    end
  end

  ////////////////////////////////////////
  // Pi
  ////////////////////////////////////////

  // Position (x,y) takes lane (x+3y mod 5, x)
  for (genvar x = 0; x < 5; x++) begin : g_pi_x
    for (genvar y = 0; y < 5; y++) begin : g_pi_y
      localparam int SrcX = (x + 3 * y) % 5;

      assign pi_data[x][y] = rho_data[SrcX][x];
    end
  end

  assign state_o = pi_data;

endmodule

//--- keccak_nonlinear_step.sv
// Keccak nonlinear layer
// Chi across each row, then iota adds the round constant to lane (0,0)

`timescale 1ns/1ps

module keccak_nonlinear_step #(
  parameter int Width = 1600
) (
  input  logic [Width-1:0]       state_i,
  input  keccak_pkg::round_idx_t rnd_i,
  output logic [Width-1:0]       state_o
);

  localparam int W = Width / 25;

  // Lane arrays, index [x][y][z]
  logic [4:0][4:0][W-1:0] lanes_in;
  logic [4:0][4:0][W-1:0] chi_data;
  logic [4:0][4:0][W-1:0] iota_data;

  // Round constant, full 64 bits then lane slice
  logic [keccak_pkg::MaxLaneW-1:0] rc_full;
  logic [W-1:0]                    rc_lane;

  assign lanes_in = state_i;

  ////////////////////////////////////////
  // Chi
  ////////////////////////////////////////

  for (genvar x = 0; x < 5; x++) begin : g_chi_x
    localparam int XP1 = (x + 1) % 5;
    localparam int XP2 = (x + 2) % 5;

    for (genvar y = 0; y < 5; y++) begin : g_chi_y
      // Only nonlinear term of the round
      assign chi_data[x][y] = lanes_in[x][y] ^ (~lanes_in[XP1][y] & lanes_in[XP2][y]);
    end
  end

  ////////////////////////////////////////
  // Iota
  ////////////////////////////////////////

  assign rc_full = keccak_pkg::RoundConst[rnd_i];

  // Narrow lanes keep the low bits
  assign rc_lane = rc_full[W-1:0];

  always_comb begin
    iota_data       = chi_data;
    // Lane (0,0) only
    iota_data[0][0] = chi_data[0][0] ^ rc_lane;
  end

  assign state_o = iota_data;

endmodule

//--- keccak_perm.sv
// Iterative Keccak-f permutation core
// One round per clock, state register and lane mapping around the round logic

`timescale 1ns/1ps

module keccak_perm #(
  // One of 200, 400, 800, 1600
  parameter int Width = 1600
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             start_i,
  input  logic [Width-1:0] state_i,
  output logic [Width-1:0] state_o,
  output logic             busy_o,
  output logic             done_o
);

  localparam int W = Width / 25;

  // Control strobes
  logic                   load;
  logic                   advance;
  keccak_pkg::round_idx_t rnd;

  // Datapath in lane order
  logic [Width-1:0] lanes_load;
  logic [Width-1:0] state_q;
  logic [Width-1:0] linear_out;
  logic [Width-1:0] round_out;

  ////////////////////////////////////////
  // Lane mapping
  ////////////////////////////////////////

  // Bit array to lane order
  // Bit w(5y+x)+z becomes lane (x,y) bit z, stored at w(5x+y)+z
  function automatic logic [Width-1:0] bits_to_lanes(logic [Width-1:0] bits);
    logic [Width-1:0] lanes;
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        lanes[W * (5 * x + y) +: W] = bits[W * (5 * y + x) +: W];
      end
    end
    return lanes;
  endfunction

  // Lane order back to bit array
  function automatic logic [Width-1:0] lanes_to_bits(logic [Width-1:0] lanes);
    logic [Width-1:0] bits;
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        bits[W * (5 * y + x) +: W] = lanes[W * (5 * x + y) +: W];
      end
    end
    return bits;
  endfunction

  assign lanes_load = bits_to_lanes(state_i);
  assign state_o    = lanes_to_bits(state_q);

  ////////////////////////////////////////
  // Round control
  ////////////////////////////////////////

  keccak_round_ctrl #(
    .Width(Width)
  ) u_round_ctrl (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start_i),
    .load_o   (load),
    .advance_o(advance),
    .rnd_o    (rnd),
    .busy_o   (busy_o),
    .done_o   (done_o)
  );

  ////////////////////////////////////////
  // Round datapath
  ////////////////////////////////////////

  // Theta, rho, pi
  keccak_linear_step #(
    .Width(Width)
  ) u_linear_step (
    .state_i(state_q),
    .state_o(linear_out)
  );

  // Chi, iota
  keccak_nonlinear_step #(
    .Width(Width)
  ) u_nonlinear_step (
    .state_i(linear_out),
    .rnd_i  (rnd),
    .state_o(round_out)
  );

  // State register, holds result while idle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= '0;
    end else if (load) begin
      state_q <= lanes_load;
    end else if (advance) begin
      state_q <= round_out;
    end
  end

endmodule

//--- tb_keccak_model.svh
// Keccak-f[1600] reference model for the testbench
// FIPS 202 step mappings written out on 64-bit lanes
`ifndef TB_KECCAK_MODEL_SVH
`define TB_KECCAK_MODEL_SVH

// Lane rotate left by n bits
function automatic logic [63:0] lane_rotl(input logic [63:0] v, input int n);
  int k;
  k = n % 64;
  if (k == 0) begin
    return v;
  end
  return (v << k) | (v >> (64 - k));
endfunction

// All 24 rounds on the bit array
function automatic logic [1599:0] keccak_f_model(input logic [1599:0] bits);
  logic [63:0]   a [5][5];
  logic [63:0]   b [5][5];
  logic [63:0]   c [5];
  logic [63:0]   d [5];
  logic [1599:0] res;
  // Bit 64(5y+x)+z is lane (x,y) bit z
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      a[x][y] = bits[64 * (5 * y + x) +: 64];
    end
  end
  for (int r = 0; r < 24; r++) begin
    // Theta
    for (int x = 0; x < 5; x++) begin
      c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x + 4) % 5] ^ lane_rotl(c[(x + 1) % 5], 1);
      for (int y = 0; y < 5; y++) begin
        a[x][y] = a[x][y] ^ d[x];
      end
    end
    // Rho and pi, B[y][2x+3y] = rot(A[x][y])
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        b[y][(2 * x + 3 * y) % 5] = lane_rotl(a[x][y], keccak_pkg::RhoOffset[5 * x + y]);
      end
    end
    // Chi
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        a[x][y] = b[x][y] ^ (~b[(x + 1) % 5][y] & b[(x + 2) % 5][y]);
      end
    end
    // Iota
    a[0][0] = a[0][0] ^ keccak_pkg::RoundConst[r];
  end
  for (int x = 0; x < 5; x++) begin
    for (int y = 0; y < 5; y++) begin
      res[64 * (5 * y + x) +: 64] = a[x][y];
    end
  end
  return res;
endfunction

`endif

//--- tb_keccak_perm.sv
// Testbench for the iterative Keccak-f[1600] core
// Table driven runs checked against a behavioral model

`timescale 1ns/1ps

module tb_keccak_perm;

  localparam int Width      = 1600;
  localparam int MaxRound   = 24;
  localparam int NumEntries = 11;
  // Watchdog budget in ns
  localparam longint LimitNs = longint'(NumEntries * 40 + 100) * 40;

  logic             clk_i;
  logic             rst_n_i;
  logic             start_i;
  logic [Width-1:0] state_i;
  logic [Width-1:0] state_o;
  logic             busy_o;
  logic             done_o;

  // Stimulus table
  logic [Width-1:0] tbl_state      [NumEntries];
  logic [63:0]      tbl_lane00     [NumEntries];
  bit               tbl_kat        [NumEntries];
  bit               tbl_busy_start [NumEntries];
  bit               tbl_abort      [NumEntries];

  int err_cnt;
  int seed_val;

  `include "tb_keccak_model.svh"

  keccak_perm #(
    .Width(Width)
  ) UUT (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .start_i(start_i),
    .state_i(state_i),
    .state_o(state_o),
    .busy_o (busy_o),
    .done_o (done_o)
  );

  // 40 ns clock
  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Normal run, optional start mid-run
  ////////////////////////////////////////

  task automatic check_permutation(input int idx);
    logic [Width-1:0]        exp_state;
    logic [Width-1:0]        held;
    keccak_pkg::ctrl_state_e seen;
    int                      edges;
    exp_state = keccak_f_model(tbl_state[idx]);
    if (tbl_kat[idx]) begin
      exp_state[63:0] = tbl_lane00[idx];
    end
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    state_i = tbl_state[idx];
    // Edge k takes the start
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    state_i = '0;
    edges   = 0;
    @(negedge clk_i);
    while (done_o !== 1'b1 && edges < MaxRound + 4) begin
      if (busy_o !== 1'b1) begin
        err_cnt++;
        $display("ERR busy_o exp=%h got=%h at edge k+%0d", 1'b1, busy_o, edges);
      end
      @(posedge clk_i);
      edges++;
      #2;
      // Second start with other data, must be dropped
      if (tbl_busy_start[idx] && edges == 6) begin
        start_i = 1'b1;
        state_i = ~tbl_state[idx];
      end else begin
        start_i = 1'b0;
        state_i = '0;
      end
      @(negedge clk_i);
    end
    seen = keccak_pkg::ctrl_state_e'(busy_o);
    if (done_o !== 1'b1) begin
      err_cnt++;
      $display("Entry %0d: done_o never rose, control in %s", idx, seen.name());
    end
    if (edges != MaxRound) begin
      err_cnt++;
      $display("ERR done_o latency exp=%h got=%h", MaxRound, edges);
    end
    if (busy_o !== 1'b0) begin
      err_cnt++;
      $display("ERR busy_o exp=%h got=%h with done_o high", 1'b0, busy_o);
    end
    if (state_o !== exp_state) begin
      err_cnt++;
      $display("ERR state_o exp=%h got=%h", exp_state, state_o);
    end
    // Result holds, done was a single pulse
    held = state_o;
    repeat (4) begin
      @(negedge clk_i);
      if (done_o !== 1'b0) begin
        err_cnt++;
        $display("ERR done_o exp=%h got=%h after the pulse", 1'b0, done_o);
      end
      if (state_o !== held) begin
        err_cnt++;
        $display("ERR state_o exp=%h got=%h while holding", held, state_o);
      end
    end
  endtask

  ////////////////////////////////////////
  // Reset in the middle of a run
  ////////////////////////////////////////

  task automatic reset_mid_run(input int idx);
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    state_i = tbl_state[idx];
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    state_i = '0;
    repeat (9) @(posedge clk_i);
    #2;
    rst_n_i = 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    if (state_o !== '0) begin
      err_cnt++;
      $display("ERR state_o exp=%h got=%h after reset", 1'b0, state_o);
    end
    if (busy_o !== 1'b0) begin
      err_cnt++;
      $display("ERR busy_o exp=%h got=%h after reset", 1'b0, busy_o);
    end
    if (done_o !== 1'b0) begin
      err_cnt++;
      $display("ERR done_o exp=%h got=%h after reset", 1'b0, done_o);
    end
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    // Aborted run must never finish
    repeat (MaxRound + 4) begin
      @(negedge clk_i);
      if (done_o !== 1'b0) begin
        err_cnt++;
        $display("ERR done_o exp=%h got=%h after mid-run reset, entry %0d", 1'b0, done_o,
                 idx);
      end
      if (state_o !== '0) begin
        err_cnt++;
        $display("ERR state_o exp=%h got=%h after mid-run reset", 1'b0, state_o);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk_i    = 1'b0;
    rst_n_i  = 1'b0;
    start_i  = 1'b0;
    state_i  = '0;
    err_cnt  = 0;
    seed_val = $urandom(64);
    // Entry 0 zero state KAT, 1..8 random, 9 start while busy, 10 reset mid-run
    for (int i = 0; i < NumEntries; i++) begin
      for (int w = 0; w < Width / 32; w++) begin
        tbl_state[i][32 * w +: 32] = $urandom();
      end
      tbl_lane00[i]     = '0;
      tbl_kat[i]        = 1'b0;
      tbl_busy_start[i] = (i == 9);
      tbl_abort[i]      = (i == 10);
    end
    tbl_state[0]  = '0;
    tbl_lane00[0] = 64'hF1258F7940E1DDE7;
    tbl_kat[0]    = 1'b1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    for (int i = 0; i < NumEntries; i++) begin
      if (tbl_abort[i]) begin
        reset_mid_run(i);
      end else begin
        check_permutation(i);
      end
    end
    $display("Summary: %0d entries run, %0d errors", NumEntries, err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog against a stuck run
  initial begin
    #(LimitNs);
    $display("Watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- compile.f
+incdir+.
keccak_pkg.sv
keccak_round_ctrl.sv
keccak_linear_step.sv
keccak_nonlinear_step.sv
keccak_perm.sv
tb_keccak_perm.sv
